// File: icache_pkg.sv
`default_nettype none

package icache_pkg;

    // ------------------------------
    // Sizes
    // ------------------------------

    // Byte address and block geometry
    localparam int ADDR_BITS   = 32;
    localparam int OFFSET_BITS = 3;
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS;
    localparam int BLOCK_BITS  = 64;
    localparam int BLOCK_BYTES = 8;

    // Fully associative store, one pool of lines
    localparam int CACHE_LINES     = 8;
    localparam int LINE_INDEX_BITS = $clog2(CACHE_LINES);
    // Internal nodes of the pseudo LRU tree
    localparam int PLRU_NODES      = CACHE_LINES - 1;

    // Memory tags, zero means no tag
    localparam int MEM_TAG_BITS = 4;
    // One entry per tag value, so the queue cannot overflow
    localparam int MSHR_DEPTH   = 1 << MEM_TAG_BITS;

    // Prefetches past a miss once the store is full
    localparam int PREFETCH_DEPTH = 7;

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [ADDR_BITS-1:0]              addr_t;
    typedef logic [TAG_BITS-1:0]               tag_t;
    typedef logic [BLOCK_BITS-1:0]             block_t;
    typedef logic [LINE_INDEX_BITS-1:0]        line_index_t;
    typedef logic [MEM_TAG_BITS-1:0]           mem_tag_t;
    typedef logic [$clog2(MSHR_DEPTH)-1:0]     mshr_ptr_t;
    typedef logic [$clog2(PREFETCH_DEPTH+1)-1:0] prefetch_count_t;

endpackage

`default_nettype wire

// File: icache_plru.sv
`default_nettype none

module icache_plru (
    input  wire logic                    clock,
    input  wire logic                    reset,
    // Older fetch port hit
    input  wire logic                    i_read0_valid,
    input  wire icache_pkg::line_index_t i_read0_index,
    // Newer fetch port hit, highest priority
    input  wire logic                    i_read1_valid,
    input  wire icache_pkg::line_index_t i_read1_index,
    // Line written by a fill, lowest priority
    input  wire logic                    i_fill_valid,
    input  wire icache_pkg::line_index_t i_fill_index,
    output logic                         o_victim_index_valid_unused_guard,
    output icache_pkg::line_index_t      o_victim_index
);

    // Tree bit set means the right subtree holds the older lines
    logic [icache_pkg::PLRU_NODES-1:0] tree;
    logic [icache_pkg::PLRU_NODES-1:0] tree_next;

    // Per-access node masks and new node values
    logic [icache_pkg::PLRU_NODES-1:0] r0_mask, r0_value;
    logic [icache_pkg::PLRU_NODES-1:0] r1_mask, r1_value;
    logic [icache_pkg::PLRU_NODES-1:0] fill_mask, fill_value;

    // Walk from the leaf up to the root, marking every node on the way
    function automatic void leaf_path(
        input  icache_pkg::line_index_t            index,
        input  logic                               valid,
        output logic [icache_pkg::PLRU_NODES-1:0] mask,
        output logic [icache_pkg::PLRU_NODES-1:0] value
    );
        int node;
        int parent;
        mask  = '0;
        value = '0;
        // Leaves sit after the internal nodes in heap order
        node  = icache_pkg::PLRU_NODES + int'(index);
        for (int level = 0; level < icache_pkg::LINE_INDEX_BITS; level++) begin
            parent = (node - 1) / 2;
            if (valid) begin
                mask[parent]  = 1'b1;
                // Odd node is a left child, so the right half becomes older
                value[parent] = node[0];
            end
            node = parent;
        end
    endfunction

    // Follow the older side from the root down to a leaf
    function automatic icache_pkg::line_index_t walk_tree(
        input logic [icache_pkg::PLRU_NODES-1:0] bits
    );
        int node;
        node = 0;
        for (int level = 0; level < icache_pkg::LINE_INDEX_BITS; level++) begin
            node = bits[node] ? (2 * node + 2) : (2 * node + 1);
        end
        return icache_pkg::line_index_t'(node - icache_pkg::PLRU_NODES);
    endfunction

    // Merge the three paths, newer read first
    always_comb begin
        leaf_path(i_read0_index, i_read0_valid, r0_mask, r0_value);
        leaf_path(i_read1_index, i_read1_valid, r1_mask, r1_value);
        leaf_path(i_fill_index, i_fill_valid, fill_mask, fill_value);
        for (int n = 0; n < icache_pkg::PLRU_NODES; n++) begin
            if (r1_mask[n]) begin
                tree_next[n] = r1_value[n];
            end else if (r0_mask[n]) begin
                tree_next[n] = r0_value[n];
            end else if (fill_mask[n]) begin
                tree_next[n] = fill_value[n];
            end else begin
                tree_next[n] = tree[n];
            end
        end
    end

    assign o_victim_index = walk_tree(tree);
    assign o_victim_index_valid_unused_guard = 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            tree <= '0;
        end else begin
            tree <= tree_next;
        end
    end

endmodule

`default_nettype wire

// File: icache_store.sv
`default_nettype none

module icache_store (
    input  wire logic               clock,
    input  wire logic               reset,
    // Fetch ports, port 0 is the older instruction
    input  wire logic [1:0]         i_read_valid,
    input  wire icache_pkg::addr_t  i_read_addr [2],
    output logic [1:0]              o_hit,
    output icache_pkg::block_t      o_read_data [2],
    // Prefetcher snoop
    input  wire logic               i_snoop_valid,
    input  wire icache_pkg::tag_t   i_snoop_tag,
    output logic                    o_snoop_found,
    output logic                    o_full,
    // Fill from the MSHR head
    input  wire logic               i_fill_valid,
    input  wire icache_pkg::tag_t   i_fill_tag,
    input  wire icache_pkg::block_t i_fill_data
);

    // ------------------------------
    // Line state
    // ------------------------------

    logic [icache_pkg::CACHE_LINES-1:0] line_valid;
    icache_pkg::tag_t                   line_tag  [icache_pkg::CACHE_LINES];
    icache_pkg::block_t                 line_data [icache_pkg::CACHE_LINES];

    // Lookup and placement
    icache_pkg::tag_t        read_tag  [2];
    icache_pkg::line_index_t hit_index [2];
    icache_pkg::line_index_t free_index;
    icache_pkg::line_index_t victim_index;
    icache_pkg::line_index_t fill_index;

    // ------------------------------
    // Read lookup
    // ------------------------------

    // Block tag is everything above the offset
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            read_tag[p] = i_read_addr[p][icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS];
        end
    end

    // Compare every line against both ports
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            o_hit[p]       = 1'b0;
            o_read_data[p] = '0;
            hit_index[p]   = '0;
            for (int l = 0; l < icache_pkg::CACHE_LINES; l++) begin
                if (i_read_valid[p] && line_valid[l] && (line_tag[l] == read_tag[p])) begin
                    o_hit[p]       = 1'b1;
                    o_read_data[p] = line_data[l];
                    hit_index[p]   = icache_pkg::line_index_t'(l);
                end
            end
        end
    end

    // Snoop answers whether the candidate block is already present
    always_comb begin
        o_snoop_found = 1'b0;
        for (int l = 0; l < icache_pkg::CACHE_LINES; l++) begin
            if (i_snoop_valid && line_valid[l] && (line_tag[l] == i_snoop_tag)) begin
                o_snoop_found = 1'b1;
            end
        end
    end

    // ------------------------------
    // Fill placement
    // ------------------------------

    // Scan downward so the lowest free line wins
    always_comb begin
        free_index = '0;
        for (int l = icache_pkg::CACHE_LINES - 1; l >= 0; l--) begin
            if (!line_valid[l]) begin
                free_index = icache_pkg::line_index_t'(l);
            end
        end
    end

    assign o_full     = &line_valid;
    // Evict only when no line is free
    assign fill_index = o_full ? victim_index : free_index;

    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else if (i_fill_valid) begin
            line_valid[fill_index] <= 1'b1;
        end
    end

    // Tag and data, readable as a hit from the next cycle
    always_ff @(posedge clock) begin
        if (i_fill_valid) begin
            line_tag[fill_index]  <= i_fill_tag;
            line_data[fill_index] <= i_fill_data;
        end
    end

    // Hits and the fill both refresh the tree
    icache_plru u_plru (
        .clock                            (clock),
        .reset                            (reset),
        .i_read0_valid                    (o_hit[0]),
        .i_read0_index                    (hit_index[0]),
        .i_read1_valid                    (o_hit[1]),
        .i_read1_index                    (hit_index[1]),
        .i_fill_valid                     (i_fill_valid),
        .i_fill_index                     (fill_index),
        .o_victim_index_valid_unused_guard(),
        .o_victim_index                   (victim_index)
    );

endmodule

`default_nettype wire

// File: icache_mshr.sv
`default_nettype none

module icache_mshr (
    input  wire logic                 clock,
    input  wire logic                 reset,
    // Prefetcher snoop
    input  wire icache_pkg::tag_t     i_snoop_tag,
    output logic                      o_snoop_found,
    // Accepted memory request
    input  wire logic                 i_push,
    input  wire icache_pkg::mem_tag_t i_push_mem_tag,
    input  wire icache_pkg::tag_t     i_push_tag,
    // Memory response tag, zero when idle
    input  wire icache_pkg::mem_tag_t i_resp_tag,
    output logic                      o_fill_valid,
    output icache_pkg::tag_t          o_fill_tag
);

    // ------------------------------
    // Queue storage
    // ------------------------------

    logic [icache_pkg::MSHR_DEPTH-1:0] entry_valid;
    icache_pkg::mem_tag_t              entry_mem_tag [icache_pkg::MSHR_DEPTH];
    icache_pkg::tag_t                  entry_tag     [icache_pkg::MSHR_DEPTH];

    // Pointers wrap with the queue depth
    icache_pkg::mshr_ptr_t head;
    icache_pkg::mshr_ptr_t tail;
    logic                  pop;

    // Responses come back in order, so only the head can match
    assign pop = (i_resp_tag != '0) && entry_valid[head] && (entry_mem_tag[head] == i_resp_tag);

    assign o_fill_valid = pop;
    assign o_fill_tag   = entry_tag[head];

    // Any outstanding entry for the snooped block
    always_comb begin
        o_snoop_found = 1'b0;
        for (int e = 0; e < icache_pkg::MSHR_DEPTH; e++) begin
            if (entry_valid[e] && (entry_tag[e] == i_snoop_tag)) begin
                o_snoop_found = 1'b1;
            end
        end
    end

    // ------------------------------
    // Push and pop
    // ------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            head        <= '0;
            tail        <= '0;
            entry_valid <= '0;
        end else begin
            if (pop) begin
                entry_valid[head] <= 1'b0;
                head              <= head + icache_pkg::mshr_ptr_t'(1);
            end
            // Push after pop, so a push into the slot being freed wins
            if (i_push) begin
                entry_valid[tail] <= 1'b1;
                tail              <= tail + icache_pkg::mshr_ptr_t'(1);
            end
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (i_push) begin
            entry_mem_tag[tail] <= i_push_mem_tag;
            entry_tag[tail]     <= i_push_tag;
        end
    end

endmodule

`default_nettype wire

// File: icache_prefetcher.sv
`default_nettype none

module icache_prefetcher (
    input  wire logic              clock,
    input  wire logic              reset,
    // Fetch ports and their hit flags
    input  wire logic [1:0]        i_read_valid,
    input  wire icache_pkg::addr_t i_read_addr [2],
    input  wire logic [1:0]        i_hit,
    // Lookup results for the candidate
    input  wire logic              i_store_full,
    input  wire logic              i_found_in_store,
    input  wire logic              i_found_in_mshr,
    input  wire logic              i_mem_req_accepted,
    output logic                   o_snoop_valid,
    output icache_pkg::tag_t       o_snoop_tag,
    output logic                   o_mem_req_valid,
    output icache_pkg::addr_t      o_mem_req_addr
);

    // Oldest missing read
    logic             miss_valid;
    icache_pkg::tag_t miss_tag;

    // Last accepted miss and last requested block
    logic                        last_valid;
    icache_pkg::tag_t            last_miss_tag;
    icache_pkg::addr_t           last_req_addr;
    icache_pkg::prefetch_count_t count;

    // Candidate for this cycle
    logic              new_miss;
    logic              prefetch_ok;
    icache_pkg::addr_t cand_addr;
    logic              accept;

    // ------------------------------
    // Candidate selection
    // ------------------------------

    // Port 0 holds the older instruction, so it goes first
    always_comb begin
        miss_valid = 1'b0;
        miss_tag   = i_read_addr[0][icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS];
        if (i_read_valid[0] && !i_hit[0]) begin
            miss_valid = 1'b1;
        end else if (i_read_valid[1] && !i_hit[1]) begin
            miss_valid = 1'b1;
            miss_tag   = i_read_addr[1][icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS];
        end
    end

    always_comb begin
        new_miss    = miss_valid && (!last_valid || (miss_tag != last_miss_tag));
        // Run ahead while lines are free, then only a bounded depth
        prefetch_ok = last_valid && (!i_store_full ||
                      ((count < icache_pkg::PREFETCH_DEPTH) && !miss_valid));
        if (new_miss) begin
            cand_addr = {miss_tag, {icache_pkg::OFFSET_BITS{1'b0}}};
        end else begin
            cand_addr = last_req_addr + icache_pkg::addr_t'(icache_pkg::BLOCK_BYTES);
        end
    end

    // ------------------------------
    // Request filter
    // ------------------------------

    assign o_snoop_valid   = new_miss || prefetch_ok;
    assign o_snoop_tag     = cand_addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS];
    // Skip blocks already cached or already outstanding
    assign o_mem_req_valid = o_snoop_valid && !i_found_in_store && !i_found_in_mshr;
    assign o_mem_req_addr  = cand_addr;
    assign accept          = o_mem_req_valid && i_mem_req_accepted;

    // State moves only on an accepted request
    always_ff @(posedge clock) begin
        if (reset) begin
            last_valid <= 1'b0;
            count      <= '0;
        end else if (accept) begin
            if (new_miss) begin
                last_valid <= 1'b1;
                count      <= '0;
            end else if (count < icache_pkg::PREFETCH_DEPTH) begin
                count <= count + icache_pkg::prefetch_count_t'(1);
            end
        end
    end

    // Miss tag and running address
    always_ff @(posedge clock) begin
        if (accept) begin
            if (new_miss) begin
                last_miss_tag <= miss_tag;
            end
            last_req_addr <= cand_addr;
        end
    end

endmodule

`default_nettype wire

// File: icache_subsystem.sv
`default_nettype none

module icache_subsystem (
    input  wire logic                 clock,
    input  wire logic                 reset,
    // Fetch side, answered in the same cycle
    input  wire logic [1:0]           i_read_valid,
    input  wire icache_pkg::addr_t    i_read_addr [2],
    output logic [1:0]                o_hit,
    output icache_pkg::block_t        o_read_data [2],
    // Memory request, counted on valid and accepted together
    output logic                      o_mem_req_valid,
    output icache_pkg::addr_t         o_mem_req_addr,
    input  wire logic                 i_mem_req_accepted,
    input  wire icache_pkg::mem_tag_t i_mem_req_tag,
    // Memory response, tags in acceptance order
    input  wire icache_pkg::mem_tag_t i_mem_resp_tag,
    input  wire icache_pkg::block_t   i_mem_resp_data
);

    // ------------------------------
    // Internal wires
    // ------------------------------

    logic             snoop_valid;
    icache_pkg::tag_t snoop_tag;
    logic             found_in_store;
    logic             found_in_mshr;
    logic             store_full;
    logic             mshr_push;
    icache_pkg::tag_t push_tag;
    logic             fill_valid;
    icache_pkg::tag_t fill_tag;

    // Accepted request enters the queue at the same edge
    assign mshr_push = o_mem_req_valid && i_mem_req_accepted;
    assign push_tag  = o_mem_req_addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS];

    icache_store u_store (
        .clock        (clock),
        .reset        (reset),
        .i_read_valid (i_read_valid),
        .i_read_addr  (i_read_addr),
        .o_hit        (o_hit),
        .o_read_data  (o_read_data),
        .i_snoop_valid(snoop_valid),
        .i_snoop_tag  (snoop_tag),
        .o_snoop_found(found_in_store),
        .o_full       (store_full),
        .i_fill_valid (fill_valid),
        .i_fill_tag   (fill_tag),
        .i_fill_data  (i_mem_resp_data)
    );

    icache_mshr u_mshr (
        .clock         (clock),
        .reset         (reset),
        .i_snoop_tag   (snoop_tag),
        .o_snoop_found (found_in_mshr),
        .i_push        (mshr_push),
        .i_push_mem_tag(i_mem_req_tag),
        .i_push_tag    (push_tag),
        .i_resp_tag    (i_mem_resp_tag),
        .o_fill_valid  (fill_valid),
        .o_fill_tag    (fill_tag)
    );

    // Hit flags feed back for oldest-miss selection
    icache_prefetcher u_prefetcher (
        .clock             (clock),
        .reset             (reset),
        .i_read_valid      (i_read_valid),
        .i_read_addr       (i_read_addr),
        .i_hit             (o_hit),
        .i_store_full      (store_full),
        .i_found_in_store  (found_in_store),
        .i_found_in_mshr   (found_in_mshr),
        .i_mem_req_accepted(i_mem_req_accepted),
        .o_snoop_valid     (snoop_valid),
        .o_snoop_tag       (snoop_tag),
        .o_mem_req_valid   (o_mem_req_valid),
        .o_mem_req_addr    (o_mem_req_addr)
    );

endmodule

`default_nettype wire

// File: icache_assert.sv
`default_nettype none

module icache_assert (
    input wire logic                 clock,
    input wire logic                 reset,
    input wire logic                 i_req_valid,
    input wire icache_pkg::addr_t    i_req_addr,
    input wire logic                 i_req_accepted,
    input wire icache_pkg::mem_tag_t i_req_tag,
    input wire icache_pkg::mem_tag_t i_resp_tag
);
    timeunit 1ns;
    timeprecision 100ps;

    // Unanswered block per memory tag
    logic [icache_pkg::MSHR_DEPTH-1:0] pending_valid;
    icache_pkg::addr_t                 pending_addr [icache_pkg::MSHR_DEPTH];
    logic                              accepted;
    logic                              duplicate;

    assign accepted = i_req_valid && i_req_accepted;

    // Same block already out at memory
    always_comb begin
        duplicate = 1'b0;
        for (int t = 0; t < icache_pkg::MSHR_DEPTH; t++) begin
            if (pending_valid[t] && (pending_addr[t] == i_req_addr)) begin
                duplicate = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_valid <= '0;
        end else begin
            if (i_resp_tag != '0) begin
                pending_valid[i_resp_tag] <= 1'b0;
            end
            if (accepted) begin
                pending_valid[i_req_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accepted) begin
            pending_addr[i_req_tag] <= i_req_addr;
        end
    end

    // ------------------------------
    // Request and fill protocol
    // ------------------------------

    req_aligned: assert property (@(posedge clock) disable iff (reset)
        i_req_valid |-> (i_req_addr[icache_pkg::OFFSET_BITS-1:0] == '0))
        else $error("memory request address is not block aligned");

    req_no_duplicate: assert property (@(posedge clock) disable iff (reset)
        accepted |-> !duplicate)
        else $error("block requested again while still outstanding");

endmodule

bind icache_subsystem icache_assert u_assert (
    .clock         (clock),
    .reset         (reset),
    .i_req_valid   (o_mem_req_valid),
    .i_req_addr    (o_mem_req_addr),
    .i_req_accepted(i_mem_req_accepted),
    .i_req_tag     (i_mem_req_tag),
    .i_resp_tag    (i_mem_resp_tag)
);

`default_nettype wire

// File: icache_tb.sv
`default_nettype none

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------
    // DUT signals
    // ------------------------------

    logic                 clock;
    logic                 reset;
    logic [1:0]           read_valid;
    icache_pkg::addr_t    read_addr [2];
    logic [1:0]           hit;
    icache_pkg::block_t   read_data [2];
    logic                 mem_req_valid;
    icache_pkg::addr_t    mem_req_addr;
    logic                 mem_req_accepted;
    icache_pkg::mem_tag_t mem_req_tag;
    icache_pkg::mem_tag_t mem_resp_tag;
    icache_pkg::block_t   mem_resp_data;

    // Memory model state, requests in acceptance order
    icache_pkg::addr_t    pend_addr [$];
    icache_pkg::mem_tag_t pend_tag [$];
    int                   pend_due [$];
    icache_pkg::addr_t    accept_log [$];
    icache_pkg::mem_tag_t next_tag;
    int                   seed = 32'h006d_2aad;

    icache_subsystem DUT (
        .clock             (clock),
        .reset             (reset),
        .i_read_valid      (read_valid),
        .i_read_addr       (read_addr),
        .o_hit             (hit),
        .o_read_data       (read_data),
        .o_mem_req_valid   (mem_req_valid),
        .o_mem_req_addr    (mem_req_addr),
        .i_mem_req_accepted(mem_req_accepted),
        .i_mem_req_tag     (mem_req_tag),
        .i_mem_resp_tag    (mem_resp_tag),
        .i_mem_resp_data   (mem_resp_data)
    );

    // ------------------------------
    // Reference model
    // ------------------------------

    // Clear the byte offset
    function automatic icache_pkg::addr_t align_block(input icache_pkg::addr_t addr);
        return {addr[icache_pkg::ADDR_BITS-1:icache_pkg::OFFSET_BITS],
                {icache_pkg::OFFSET_BITS{1'b0}}};
    endfunction

    // Block contents: aligned address on top, its inversion below
    function automatic icache_pkg::block_t block_of(input icache_pkg::addr_t addr);
        icache_pkg::addr_t aligned;
        aligned = align_block(addr);
        return {aligned, ~aligned};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_block(input string name, input icache_pkg::block_t got,
                                 input icache_pkg::block_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("Block data mismatch");
        end
    endtask

    task automatic compare_addr(input string name, input icache_pkg::addr_t got,
                                input icache_pkg::addr_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("Address mismatch");
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run("Flag mismatch");
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step_to_drive();
        @(posedge clock);
        #1;
    endtask

    // Keep the given ports reading, each dropped once it has hit
    task automatic wait_hits(input logic [1:0] ports, input int limit);
        logic [1:0] seen;
        int         waited;
        seen   = 2'b00;
        waited = 0;
        while (seen != ports) begin
            if (waited == limit) begin
                abort_run($sformatf("Timeout: fetch ports %b did not hit within %0d cycles",
                                    ports & ~seen, limit));
            end else begin
                @(negedge clock);
                seen = seen | (hit & ports);
                waited++;
                if (seen != ports) begin
                    step_to_drive();
                    read_valid = read_valid & ~seen;
                end
            end
        end
    endtask

    task automatic wait_log(input int target, input int limit);
        int waited;
        waited = 0;
        while (accept_log.size() < target) begin
            if (waited == limit) begin
                abort_run("Timeout: too few memory requests were accepted");
            end else begin
                @(negedge clock);
                waited++;
            end
        end
    endtask

    // ------------------------------
    // Clock, memory, checker
    // ------------------------------

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #5 clock = ~clock;
        end
    end

    initial begin : memory_model
        int cycle;
        cycle            = 0;
        next_tag         = icache_pkg::mem_tag_t'(1);
        mem_req_accepted = 1'b0;
        mem_req_tag      = '0;
        mem_resp_tag     = '0;
        mem_resp_data    = '0;
        forever begin
            step_to_drive();
            cycle++;
            // One in-order response per cycle once due
            if ((pend_addr.size() > 0) && (pend_due[0] <= cycle)) begin
                mem_resp_tag  = pend_tag[0];
                mem_resp_data = block_of(pend_addr[0]);
                pend_tag.delete(0);
                pend_addr.delete(0);
                pend_due.delete(0);
            end else begin
                mem_resp_tag  = '0;
                mem_resp_data = '0;
            end
            // Random stalls, and back-pressure with many in flight
            mem_req_accepted = (pend_addr.size() < 12) && (($random(seed) & 3) != 0);
            mem_req_tag      = next_tag;
            // Outputs are settled mid-cycle, same as at the next edge
            @(negedge clock);
            if (!reset && mem_req_valid && mem_req_accepted) begin
                pend_addr.push_back(mem_req_addr);
                pend_tag.push_back(next_tag);
                pend_due.push_back(cycle + 2 + ($random(seed) & 7));
                accept_log.push_back(mem_req_addr);
                // Tags run 1 to 15, zero is reserved
                if (next_tag == icache_pkg::mem_tag_t'(15)) begin
                    next_tag = icache_pkg::mem_tag_t'(1);
                end else begin
                    next_tag = next_tag + icache_pkg::mem_tag_t'(1);
                end
            end
        end
    end

    // Every hit must return the block of its own address
    initial begin : compare_reads
        forever begin
            @(negedge clock);
            if (!reset) begin
                for (int k = 0; k < 2; k++) begin
                    if (hit[k]) begin
                        compare_block($sformatf("o_read_data[%0d]", k), read_data[k],
                                      block_of(read_addr[k]));
                    end
                    if (!read_valid[k]) begin
                        compare_flag($sformatf("o_hit[%0d]", k), hit[k], 1'b0);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        repeat (200000) @(posedge clock);
        abort_run("Timeout: the run did not finish");
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin : stimulus
        icache_pkg::addr_t miss_addr;
        icache_pkg::addr_t region;
        int                start;
        int                port;
        int                blk;
        reset        = 1'b1;
        read_valid   = 2'b00;
        read_addr[0] = '0;
        read_addr[1] = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        // Idle: nothing requested, nothing hit
        repeat (4) begin
            @(negedge clock);
            compare_flag("o_mem_req_valid", mem_req_valid, 1'b0);
            compare_flag("o_hit[0]", hit[0], 1'b0);
            compare_flag("o_hit[1]", hit[1], 1'b0);
        end

        // Port 0 miss requests its own block in the same cycle
        miss_addr = 32'h0000_4a14;
        start     = accept_log.size();
        step_to_drive();
        read_valid   = 2'b01;
        read_addr[0] = miss_addr;
        @(negedge clock);
        compare_flag("o_mem_req_valid", mem_req_valid, 1'b1);
        compare_addr("o_mem_req_addr", mem_req_addr, align_block(miss_addr));
        wait_hits(2'b01, 1000);

        // Prefetch walks forward one block at a time
        // Port 0 keeps hitting its block so that line stays recently used
        wait_log(start + 8, 1000);
        for (int i = 0; i < 8; i++) begin
            compare_addr($sformatf("o_mem_req_addr (accepted request %0d)", i),
                         accept_log[start + i],
                         align_block(miss_addr) +
                         icache_pkg::addr_t'(i * icache_pkg::BLOCK_BYTES));
        end

        // Prefetched blocks hit, alternating ports
        for (int i = 0; i < 8; i++) begin
            port = i % 2;
            step_to_drive();
            read_valid       = 2'b00;
            read_valid[port] = 1'b1;
            read_addr[port]  = align_block(miss_addr) +
                               icache_pkg::addr_t'(i * icache_pkg::BLOCK_BYTES + 4);
            wait_hits(2'(1 << port), 1000);
        end

        // 40 blocks over 8 lines, so lines get evicted and refilled
        region = 32'h0002_0000;
        for (int n = 0; n < 60; n++) begin
            step_to_drive();
            read_valid = 2'b11;
            for (int k = 0; k < 2; k++) begin
                blk          = ($random(seed) & 32'h7fff_ffff) % 40;
                read_addr[k] = region + icache_pkg::addr_t'(blk * icache_pkg::BLOCK_BYTES) +
                               icache_pkg::addr_t'($random(seed) & 7);
            end
            wait_hits(2'b11, 1000);
        end

        step_to_drive();
        read_valid = 2'b00;
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
icache_pkg.sv
icache_plru.sv
icache_store.sv
icache_mshr.sv
icache_prefetcher.sv
icache_subsystem.sv
icache_assert.sv
icache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f filelist.f --top-module icache_tb -Mdir obj_dir -o icache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/icache_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
